// ==== sim/pinmux_stim.txt ====
# op name a b c, fields in hex
# W addr data be | R addr expect - | P pads txd - | C mask out oen | U rxd - -
# M source period - (source ff is pulse1m_o) | G count - - | I count - -
C reset_pads 00ffffff 00000000 00ffffff
W pwm0_full 14 aabbccdd f
W pwm0_bytes 14 11223344 5
R pwm0_rd 14 aa22cc44 0
W tick_wr 10 fffffc04 f
R tick_rd 10 00000004 0
W gpio_in_wr 0c 12345678 f
R gpio_in_ro 0c 00000000 0
R unmapped 40 00000000 0
G gpio_out_rand 8 0 0
I gpio_in_rand 8 0 0
W dir_all 04 00ffffff f
W out_pat 08 00a5a5a5 f
W uart_on 00 00000100 f
P txd_high 00000000 1 0
C uart_tx1 00000006 00000004 00000002
U rxd_lo 0 0 0
P rx_high 00000002 0 0
C uart_tx0 00000006 00000000 00000002
U rxd_hi 1 0 0
W uart_off 00 00000000 f
C uart_gpio 00000006 00000004 00000000
U rxd_off 0 0 0
W dir_in 04 00000000 f
W pwm1_cfg 18 00030002 f
W pwm1_on 00 00000002 f
C pwm_pad 00000100 00000100 00000000
R func_rd 00 00000002 0
M pwm_period 08 64 0
M ms_period ff 14 0

// ==== sim.f ====
verilog/pinmux_reg_pkg.sv
verilog/pinmux_pad_pkg.sv
verilog/pad_cfg_if.sv
verilog/pinmux_regs.sv
verilog/tick_gen.sv
verilog/pwm_wave.sv
verilog/pad_mux.sv
verilog/pinmux_top.sv
sim/pinmux_sva.sv
sim/pinmux_tb.sv

// ==== sim/pinmux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_tb;

  localparam int N_PADS     = pinmux_pad_pkg::N_PADS;
  localparam int PAD_MASK   = 32'h00ff_ffff;
  localparam int ACK_LIMIT  = 8;
  // PWM measure at most 5 x 100 clocks, ms strobe measure 5 x 20
  // Register and GPIO traffic stays near 300 clocks
  localparam int MAX_CYCLES = 5000;

  logic                              mclk;
  logic                              rst_n_i;
  logic                              reg_cs_i;
  logic                              reg_wr_i;
  logic [pinmux_reg_pkg::REG_AW-1:0] reg_addr_i;
  logic [pinmux_reg_pkg::REG_DW-1:0] reg_wdata_i;
  logic [3:0]                        reg_be_i;
  logic [pinmux_reg_pkg::REG_DW-1:0] reg_rdata_o;
  logic                              reg_ack_o;
  logic [N_PADS-1:0]                 digital_io_in_i;
  logic [N_PADS-1:0]                 digital_io_out_o;
  logic [N_PADS-1:0]                 digital_io_oen_o;
  logic                              uart_txd_i;
  logic                              uart_rxd_o;
  logic                              pulse1m_o;

  integer seed;
  int     cycles;
  int     errors;
  int     tests;
  int     failed_tests;

  pinmux_top #(
    .TICKS_PER_MS (4)
  ) i_pinmux_top (
    .mclk             (mclk),
    .rst_n_i          (rst_n_i),
    .reg_cs_i         (reg_cs_i),
    .reg_wr_i         (reg_wr_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .reg_be_i         (reg_be_i),
    .reg_rdata_o      (reg_rdata_o),
    .reg_ack_o        (reg_ack_o),
    .digital_io_in_i  (digital_io_in_i),
    .digital_io_out_o (digital_io_out_o),
    .digital_io_oen_o (digital_io_oen_o),
    .uart_txd_i       (uart_txd_i),
    .uart_rxd_o       (uart_rxd_o),
    .pulse1m_o        (pulse1m_o)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////
  initial mclk = 1'b0;
  always #5 mclk = ~mclk;

  always @(posedge mclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // Compare one value, report on the spot
  task automatic check_value(input logic [8*24-1:0] name, input logic [8*8-1:0] what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("mismatch %0s %0s: expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////
  // One strobe, then wait for ack with a limit
  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output logic [31:0] rdata);
    int lat;
    @(posedge mclk);
    reg_cs_i    <= 1'b1;
    reg_wr_i    <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    reg_be_i    <= be;
    @(posedge mclk);
    reg_cs_i <= 1'b0;
    reg_wr_i <= 1'b0;
    lat = 1;
    @(negedge mclk);
    while (!reg_ack_o && lat < ACK_LIMIT) begin
      @(negedge mclk);
      lat++;
    end
    rdata = reg_rdata_o;
    assert (reg_ack_o) else begin
      $display("no acknowledge within %0d cycles at address %h", ACK_LIMIT, addr);
      errors++;
    end
    if (reg_ack_o) begin
      assert (lat == 1) else begin
        $display("acknowledge came %0d cycles after cs instead of 1", lat);
        errors++;
      end
    end
  endtask

  // Pads under a mask, sampled mid cycle
  task automatic check_pads(input logic [8*24-1:0] name, input logic [31:0] mask,
                            input logic [31:0] exp_out, input logic [31:0] exp_oen);
    @(negedge mclk);
    check_value(name, "out", exp_out, {8'h00, digital_io_out_o} & mask);
    check_value(name, "oen", exp_oen, {8'h00, digital_io_oen_o} & mask);
  endtask

  // Source ff is the ms strobe, else a pad output
  function automatic logic pick_signal(input logic [7:0] src);
    if (src == 8'hff) begin
      return pulse1m_o;
    end else begin
      return digital_io_out_o[src];
    end
  endfunction

  ////////////////////////////////////////
  // Period measurement
  ////////////////////////////////////////
  // First rising edge starts the count, then three periods
  task automatic measure_period(input logic [8*24-1:0] name, input logic [7:0] src,
                                input int exp);
    logic prev;
    logic cur;
    int   since;
    int   edges;
    int   waited;
    @(negedge mclk);
    prev   = pick_signal(src);
    since  = 0;
    edges  = 0;
    waited = 0;
    while (edges < 4 && waited < 5 * exp) begin
      @(negedge mclk);
      waited++;
      since++;
      cur = pick_signal(src);
      if (cur && !prev) begin
        if (edges > 0) check_value(name, "period", exp, since);
        edges++;
        since = 0;
      end
      prev = cur;
    end
    assert (edges == 4) else begin
      $display("%0s saw only %0d rising edges in %0d cycles", name, edges, waited);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Random GPIO tests
  ////////////////////////////////////////
  // Out is data AND dir, oen is NOT dir
  task automatic gpio_out_random(input logic [8*24-1:0] name, input int count);
    logic [31:0] dir;
    logic [31:0] dout;
    logic [31:0] unused;
    for (int i = 0; i < count; i++) begin
      dir  = $random(seed) & PAD_MASK;
      dout = $random(seed) & PAD_MASK;
      bus_access(1'b1, pinmux_reg_pkg::ADDR_GPIO_DIR, dir, 4'hf, unused);
      bus_access(1'b1, pinmux_reg_pkg::ADDR_GPIO_OUT, dout, 4'hf, unused);
      check_value(name, "out", dout & dir, {8'h00, digital_io_out_o});
      check_value(name, "oen", ~dir & PAD_MASK, {8'h00, digital_io_oen_o});
    end
  endtask

  // Two sync flops, read after three cycles
  task automatic gpio_in_random(input logic [8*24-1:0] name, input int count);
    logic [31:0] pins;
    logic [31:0] rd;
    for (int i = 0; i < count; i++) begin
      pins = $random(seed) & PAD_MASK;
      @(posedge mclk);
      digital_io_in_i <= pins[N_PADS-1:0];
      repeat (3) @(posedge mclk);
      bus_access(1'b0, pinmux_reg_pkg::ADDR_GPIO_IN, 32'h0, 4'hf, rd);
      check_value(name, "gpio_in", pins, rd);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : main
    int               fd;
    int               n;
    int               err_before;
    int               sva_fails;
    logic [8*128-1:0] line;
    logic [8*8-1:0]   op;
    logic [8*24-1:0]  name;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [31:0]      rd;
    seed            = 32'h3db7206a;
    cycles          = 0;
    errors          = 0;
    tests           = 0;
    failed_tests    = 0;
    rst_n_i         = 1'b0;
    reg_cs_i        = 1'b0;
    reg_wr_i        = 1'b0;
    reg_addr_i      = '0;
    reg_wdata_i     = '0;
    reg_be_i        = 4'h0;
    digital_io_in_i = '0;
    uart_txd_i      = 1'b0;
    repeat (3) @(posedge mclk);
    rst_n_i <= 1'b1;

    fd = $fopen("sim/pinmux_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file sim/pinmux_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        op   = '0;
        n    = $fgets(line, fd);
        n    = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
        // Comment and blank lines carry no op
        if (n >= 2 && op != "#") begin
          err_before = errors;
          case (op)
            "W": bus_access(1'b1, a[7:0], b, c[3:0], rd);
            "R": begin
              bus_access(1'b0, a[7:0], 32'h0, 4'hf, rd);
              check_value(name, "rdata", b, rd);
            end
            "P": begin
              @(posedge mclk);
              digital_io_in_i <= a[N_PADS-1:0];
              uart_txd_i      <= b[0];
              @(negedge mclk);
            end
            "C": check_pads(name, a, b, c);
            "U": begin
              @(negedge mclk);
              check_value(name, "rxd", a, {31'h0, uart_rxd_o});
            end
            "M": measure_period(name, a[7:0], b);
            "G": gpio_out_random(name, a);
            "I": gpio_in_random(name, a);
            default: begin
              $display("unknown stimulus op in test %0s", name);
              errors++;
            end
          endcase
          tests++;
          if (errors != err_before) failed_tests++;
          $display("%0s %0s", (errors == err_before) ? "pass" : "FAIL", name);
        end
      end
      $fclose(fd);
    end

    // Bound bus and reset assertions count their own failures
    sva_fails = i_pinmux_top.i_pinmux_sva.fail_count;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests, failed_tests, errors, sva_fails);
    if (errors == 0 && failed_tests == 0 && sva_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/pinmux_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_sva (
  input wire logic                              mclk,
  input wire logic                              rst_n_i,
  input wire logic                              reg_cs_i,
  input wire logic                              reg_ack_o,
  input wire logic [pinmux_pad_pkg::N_PADS-1:0] digital_io_oen_o
);

  // Failed assertion count, read by the testbench
  int fail_count = 0;

  ////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////
  // Ack is cs delayed by one clock
  ack_follows_cs: assert property (
    @(posedge mclk) disable iff (!rst_n_i) reg_ack_o == $past(reg_cs_i)
  ) else begin
    $error("reg_ack_o does not follow reg_cs_i by one cycle");
    fail_count++;
  end

  // Single cycle pulse
  ack_one_cycle: assert property (
    @(posedge mclk) disable iff (!rst_n_i) reg_ack_o |=> !reg_ack_o
  ) else begin
    $error("reg_ack_o held high for two cycles");
    fail_count++;
  end

  // All pads released in reset
  oen_in_reset: assert property (
    @(posedge mclk) !rst_n_i |-> (&digital_io_oen_o)
  ) else begin
    $error("a pad is driven while reset is asserted");
    fail_count++;
  end

endmodule

bind pinmux_top pinmux_sva i_pinmux_sva (
  .mclk             (mclk),
  .rst_n_i          (rst_n_i),
  .reg_cs_i         (reg_cs_i),
  .reg_ack_o        (reg_ack_o),
  .digital_io_oen_o (digital_io_oen_o)
);

`default_nettype wire

// ==== verilog/pinmux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_top #(
  parameter int TICKS_PER_MS = 1000
) (
  input  wire logic                                mclk,
  input  wire logic                                rst_n_i,
  // Register bus
  input  wire logic                                reg_cs_i,
  input  wire logic                                reg_wr_i,
  input  wire logic [pinmux_reg_pkg::REG_AW-1:0]   reg_addr_i,
  input  wire logic [pinmux_reg_pkg::REG_DW-1:0]   reg_wdata_i,
  input  wire logic [3:0]                          reg_be_i,
  output logic      [pinmux_reg_pkg::REG_DW-1:0]   reg_rdata_o,
  output logic                                     reg_ack_o,
  // Pads
  input  wire logic [pinmux_pad_pkg::N_PADS-1:0]   digital_io_in_i,
  output logic      [pinmux_pad_pkg::N_PADS-1:0]   digital_io_out_o,
  output logic      [pinmux_pad_pkg::N_PADS-1:0]   digital_io_oen_o,
  // UART
  input  wire logic                                uart_txd_i,
  output logic                                     uart_rxd_o,
  // Millisecond strobe
  output logic                                     pulse1m_o
);

  logic [pinmux_reg_pkg::TICK_DIV_W-1:0]           tick_div;
  logic [pinmux_reg_pkg::N_PWM-1:0]                pwm_enb;
  pinmux_reg_pkg::pwm_cfg_u [pinmux_reg_pkg::N_PWM-1:0] pwm_cfg;
  logic [pinmux_reg_pkg::N_PWM-1:0]                pwm_wave;

  // Pad config between register bank and mux
  pad_cfg_if i_pad_cfg ();

  ////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////
  pinmux_regs i_pinmux_regs (
    .mclk        (mclk),
    .rst_n_i     (rst_n_i),
    .reg_cs_i    (reg_cs_i),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .pad_cfg     (i_pad_cfg.regs),
    .tick_div_o  (tick_div),
    .pwm_enb_o   (pwm_enb),
    .pwm_cfg_o   (pwm_cfg)
  );

  // us strobe stays internal to the tick block
  tick_gen #(
    .TICKS_PER_MS (TICKS_PER_MS)
  ) i_tick_gen (
    .mclk       (mclk),
    .rst_n_i    (rst_n_i),
    .tick_div_i (tick_div),
    .pulse1u_o  (),
    .pulse1m_o  (pulse1m_o)
  );

  ////////////////////////////////////////
  // PWM channels
  ////////////////////////////////////////
  for (genvar c = 0; c < pinmux_reg_pkg::N_PWM; c++) begin : g_pwm
    pwm_wave i_pwm_wave (
      .mclk      (mclk),
      .rst_n_i   (rst_n_i),
      .pulse1m_i (pulse1m_o),
      .enb_i     (pwm_enb[c]),
      .cfg_i     (pwm_cfg[c]),
      .wave_o    (pwm_wave[c])
    );
  end

  // Pad selection
  pad_mux i_pad_mux (
    .pad_cfg          (i_pad_cfg.mux),
    .pwm_enb_i        (pwm_enb),
    .pwm_wave_i       (pwm_wave),
    .uart_txd_i       (uart_txd_i),
    .digital_io_in_i  (digital_io_in_i),
    .digital_io_out_o (digital_io_out_o),
    .digital_io_oen_o (digital_io_oen_o),
    .uart_rxd_o       (uart_rxd_o)
  );

endmodule

`default_nettype wire

// ==== verilog/pad_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_mux (
  pad_cfg_if.mux                                  pad_cfg,
  input  wire logic [pinmux_reg_pkg::N_PWM-1:0]   pwm_enb_i,
  input  wire logic [pinmux_reg_pkg::N_PWM-1:0]   pwm_wave_i,
  input  wire logic                               uart_txd_i,
  input  wire logic [pinmux_pad_pkg::N_PADS-1:0]  digital_io_in_i,
  output logic      [pinmux_pad_pkg::N_PADS-1:0]  digital_io_out_o,
  output logic      [pinmux_pad_pkg::N_PADS-1:0]  digital_io_oen_o,
  output logic                                    uart_rxd_o
);

  ////////////////////////////////////////
  // Pad input
  ////////////////////////////////////////
  // Raw pad values back to the register side
  assign pad_cfg.pad_in = digital_io_in_i;

  // UART rx only while UART owns its pad
  assign uart_rxd_o = pad_cfg.uart_enb & digital_io_in_i[pinmux_pad_pkg::UART_RX_PAD];

  ////////////////////////////////////////
  // Pad output and output enable
  ////////////////////////////////////////
  // Lowest priority first, later stages override
  always_comb begin
    // GPIO
    // Output pads drive the out bit, input pads float with out 0
    digital_io_out_o = pad_cfg.gpio_out & pad_cfg.gpio_dir;
    digital_io_oen_o = ~pad_cfg.gpio_dir;

    // UART
    if (pad_cfg.uart_enb) begin
      // Rx pad forced to input
      digital_io_out_o[pinmux_pad_pkg::UART_RX_PAD] = 1'b0;
      digital_io_oen_o[pinmux_pad_pkg::UART_RX_PAD] = 1'b1;
      // Tx pad driven by the UART
      digital_io_out_o[pinmux_pad_pkg::UART_TX_PAD] = uart_txd_i;
      digital_io_oen_o[pinmux_pad_pkg::UART_TX_PAD] = 1'b0;
    end

    // PWM wins over UART and GPIO on its pad
    for (int c = 0; c < pinmux_reg_pkg::N_PWM; c++) begin
      if (pwm_enb_i[c]) begin
        digital_io_out_o[pinmux_pad_pkg::PWM_PAD[c]] = pwm_wave_i[c];
        digital_io_oen_o[pinmux_pad_pkg::PWM_PAD[c]] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pwm_wave.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_wave (
  input  wire logic                     mclk,
  input  wire logic                     rst_n_i,
  input  wire logic                     pulse1m_i,
  input  wire logic                     enb_i,
  input  pinmux_reg_pkg::pwm_cfg_u      cfg_i,
  output logic                          wave_o
);

  localparam int CW = pinmux_reg_pkg::PWM_CNT_W;

  // Phase 1 is the high part of the period
  logic          phase_q;
  logic [CW-1:0] cnt_q;
  logic [CW-1:0] limit;
  logic          last;

  // Length of the running phase in ms strobes
  assign limit = phase_q ? cfg_i.fld.high : cfg_i.fld.low;
  // Zero length behaves like one strobe
  assign last  = ({1'b0, cnt_q} + 1'b1) >= {1'b0, limit};

  ////////////////////////////////////////
  // Phase counter
  ////////////////////////////////////////
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= 1'b1;
      cnt_q   <= '0;
    end else if (!enb_i) begin
      // Idle, restart high on next enable
      phase_q <= 1'b1;
      cnt_q   <= '0;
    end else if (pulse1m_i) begin
      if (last) begin
        phase_q <= ~phase_q;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Low whenever the channel is off
  assign wave_o = enb_i & phase_q;

endmodule

`default_nettype wire

// ==== verilog/tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
  parameter int TICKS_PER_MS = 1000
) (
  input  wire logic                                  mclk,
  input  wire logic                                  rst_n_i,
  input  wire logic [pinmux_reg_pkg::TICK_DIV_W-1:0] tick_div_i,
  output logic                                       pulse1u_o,
  output logic                                       pulse1m_o
);

  localparam int MS_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;

  logic [pinmux_reg_pkg::TICK_DIV_W-1:0] us_cnt_q;
  logic                                  us_hit;
  logic                                  pulse1u_q;
  logic [MS_W-1:0]                       ms_cnt_q;
  logic                                  pulse1m_q;

  ////////////////////////////////////////
  // Microsecond strobe
  ////////////////////////////////////////
  // Down-counter, reload on zero
  // One strobe every tick_div + 1 clocks
  assign us_hit = (us_cnt_q == '0);

  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      us_cnt_q  <= '0;
      pulse1u_q <= 1'b0;
    end else begin
      us_cnt_q  <= us_hit ? tick_div_i : us_cnt_q - 1'b1;
      pulse1u_q <= us_hit;
    end
  end

  ////////////////////////////////////////
  // Millisecond strobe
  ////////////////////////////////////////
  // Every TICKS_PER_MS-th microsecond strobe
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ms_cnt_q  <= '0;
      pulse1m_q <= 1'b0;
    end else begin
      pulse1m_q <= 1'b0;
      if (pulse1u_q) begin
        if (ms_cnt_q == MS_W'(TICKS_PER_MS - 1)) begin
          ms_cnt_q  <= '0;
          pulse1m_q <= 1'b1;
        end else begin
          ms_cnt_q <= ms_cnt_q + 1'b1;
        end
      end
    end
  end

  assign pulse1u_o = pulse1u_q;
  assign pulse1m_o = pulse1m_q;

endmodule

`default_nettype wire

// ==== verilog/pinmux_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_regs (
  input  wire logic                                mclk,
  input  wire logic                                rst_n_i,
  // Register bus
  input  wire logic                                reg_cs_i,
  input  wire logic                                reg_wr_i,
  input  wire logic [pinmux_reg_pkg::REG_AW-1:0]   reg_addr_i,
  input  wire logic [pinmux_reg_pkg::REG_DW-1:0]   reg_wdata_i,
  input  wire logic [3:0]                          reg_be_i,
  output logic      [pinmux_reg_pkg::REG_DW-1:0]   reg_rdata_o,
  output logic                                     reg_ack_o,
  // Pad configuration
  pad_cfg_if.regs                                  pad_cfg,
  // Tick and PWM configuration
  output logic      [pinmux_reg_pkg::TICK_DIV_W-1:0] tick_div_o,
  output logic      [pinmux_reg_pkg::N_PWM-1:0]      pwm_enb_o,
  output pinmux_reg_pkg::pwm_cfg_u [pinmux_reg_pkg::N_PWM-1:0] pwm_cfg_o
);

  localparam int AW = pinmux_reg_pkg::REG_AW;
  localparam int DW = pinmux_reg_pkg::REG_DW;
  localparam int NP = pinmux_reg_pkg::N_PWM;

  // Configuration state
  logic [NP-1:0]                             pwm_enb_q;
  logic                                      uart_enb_q;
  logic [pinmux_pad_pkg::N_PADS-1:0]         gpio_dir_q;
  logic [pinmux_pad_pkg::N_PADS-1:0]         gpio_out_q;
  logic [pinmux_reg_pkg::TICK_DIV_W-1:0]     tick_div_q;
  pinmux_reg_pkg::pwm_cfg_u [NP-1:0]         pwm_cfg_q;
  // Two-flop pad input synchronizer
  logic [pinmux_pad_pkg::N_PADS-1:0]         sync1_q;
  logic [pinmux_pad_pkg::N_PADS-1:0]         sync2_q;
  // Bus datapath
  logic [DW-1:0]                             rd_mux;
  logic [DW-1:0]                             wr_data;
  logic                                      wr_en;
  logic [DW-1:0]                             rdata_q;
  logic                                      ack_q;

  // Byte address of PWM channel n
  function automatic logic [AW-1:0] pwm_addr(input int unsigned n);
    return pinmux_reg_pkg::ADDR_PWM_BASE + AW'(4 * n);
  endfunction

  // Replace enabled byte lanes of the current word
  function automatic logic [DW-1:0] merge_be(
    input logic [DW-1:0] cur,
    input logic [DW-1:0] wdata,
    input logic [3:0]    be
  );
    logic [DW-1:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////
  always_comb begin
    rd_mux = '0;
    case (reg_addr_i)
      pinmux_reg_pkg::ADDR_FUNC_SEL: begin
        rd_mux[NP-1:0]                       = pwm_enb_q;
        rd_mux[pinmux_reg_pkg::FUNC_UART_BIT] = uart_enb_q;
      end
      pinmux_reg_pkg::ADDR_GPIO_DIR: rd_mux[pinmux_pad_pkg::N_PADS-1:0] = gpio_dir_q;
      pinmux_reg_pkg::ADDR_GPIO_OUT: rd_mux[pinmux_pad_pkg::N_PADS-1:0] = gpio_out_q;
      pinmux_reg_pkg::ADDR_GPIO_IN:  rd_mux[pinmux_pad_pkg::N_PADS-1:0] = sync2_q;
      pinmux_reg_pkg::ADDR_TICK_DIV: rd_mux[pinmux_reg_pkg::TICK_DIV_W-1:0] = tick_div_q;
      default: ;
    endcase
    // PWM window
    for (int n = 0; n < NP; n++) begin
      if (reg_addr_i == pwm_addr(n)) rd_mux = pwm_cfg_q[n].raw;
    end
  end

  // Current contents merged with the written bytes
  assign wr_en   = reg_cs_i & reg_wr_i;
  assign wr_data = merge_be(rd_mux, reg_wdata_i, reg_be_i);

  ////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pwm_enb_q  <= '0;
      uart_enb_q <= 1'b0;
      gpio_dir_q <= '0;
      gpio_out_q <= '0;
      tick_div_q <= '0;
      pwm_cfg_q  <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        pinmux_reg_pkg::ADDR_FUNC_SEL: begin
          pwm_enb_q  <= wr_data[NP-1:0];
          uart_enb_q <= wr_data[pinmux_reg_pkg::FUNC_UART_BIT];
        end
        pinmux_reg_pkg::ADDR_GPIO_DIR: gpio_dir_q <= wr_data[pinmux_pad_pkg::N_PADS-1:0];
        pinmux_reg_pkg::ADDR_GPIO_OUT: gpio_out_q <= wr_data[pinmux_pad_pkg::N_PADS-1:0];
        pinmux_reg_pkg::ADDR_TICK_DIV: tick_div_q <= wr_data[pinmux_reg_pkg::TICK_DIV_W-1:0];
        // GPIO_IN is read only
        default: ;
      endcase
      for (int n = 0; n < NP; n++) begin
        if (reg_addr_i == pwm_addr(n)) pwm_cfg_q[n].raw <= wr_data;
      end
    end
  end

  // Ack one cycle after cs, read data only alongside a read ack
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q   <= reg_cs_i;
      rdata_q <= (reg_cs_i && !reg_wr_i) ? rd_mux : '0;
    end
  end

  // Pad inputs cross into mclk here
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_cfg.pad_in;
      sync2_q <= sync1_q;
    end
  end

  // Outputs
  assign reg_ack_o        = ack_q;
  assign reg_rdata_o      = rdata_q;
  assign pad_cfg.gpio_dir = gpio_dir_q;
  assign pad_cfg.gpio_out = gpio_out_q;
  assign pad_cfg.uart_enb = uart_enb_q;
  assign tick_div_o       = tick_div_q;
  assign pwm_enb_o        = pwm_enb_q;
  assign pwm_cfg_o        = pwm_cfg_q;

endmodule

`default_nettype wire

// ==== verilog/pad_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pad_cfg_if;

  // GPIO direction, 1 drives the pad
  logic [pinmux_pad_pkg::N_PADS-1:0] gpio_dir;
  // GPIO output data
  logic [pinmux_pad_pkg::N_PADS-1:0] gpio_out;
  // UART takes over its two pads
  logic                              uart_enb;
  // Raw pad input, not yet synchronized
  logic [pinmux_pad_pkg::N_PADS-1:0] pad_in;

  // Register side
  modport regs (
    output gpio_dir,
    output gpio_out,
    output uart_enb,
    input  pad_in
  );

  // Pad mux side
  modport mux (
    input  gpio_dir,
    input  gpio_out,
    input  uart_enb,
    output pad_in
  );

endinterface

`default_nettype wire

// ==== verilog/pinmux_pad_pkg.sv ====
`default_nettype none

package pinmux_pad_pkg;

  ////////////////////////////////////////
  // Pad ring
  ////////////////////////////////////////
  // Pad k carries GPIO bit k
  localparam int N_PADS = 24;

  ////////////////////////////////////////
  // Alternate function pads
  ////////////////////////////////////////
  // PWM channel to pad table
  // Channel 0 drives pad 4, channel 5 drives pad 14
  localparam int unsigned PWM_PAD [pinmux_reg_pkg::N_PWM] = '{
    4,
    8,
    9,
    12,
    13,
    14
  };

  // UART receive, pad is input only when enabled
  localparam int unsigned UART_RX_PAD = 1;

  // UART transmit, pad is always driven when enabled
  localparam int unsigned UART_TX_PAD = 2;

endpackage

`default_nettype wire

// ==== verilog/pinmux_reg_pkg.sv ====
`default_nettype none

package pinmux_reg_pkg;

  ////////////////////////////////////////
  // Register bus geometry
  ////////////////////////////////////////
  localparam int REG_AW = 8;
  localparam int REG_DW = 32;

  // Byte addresses, word aligned
  localparam logic [REG_AW-1:0] ADDR_FUNC_SEL = 8'h00;
  localparam logic [REG_AW-1:0] ADDR_GPIO_DIR = 8'h04;
  localparam logic [REG_AW-1:0] ADDR_GPIO_OUT = 8'h08;
  localparam logic [REG_AW-1:0] ADDR_GPIO_IN  = 8'h0C;
  localparam logic [REG_AW-1:0] ADDR_TICK_DIV = 8'h10;
  // PWM channel n sits at base + 4n
  localparam logic [REG_AW-1:0] ADDR_PWM_BASE = 8'h14;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////
  localparam int TICK_DIV_W    = 10;
  localparam int PWM_CNT_W     = 16;
  localparam int N_PWM         = 6;
  // FUNC_SEL bit 8, PWM enables live in bits 5:0
  localparam int FUNC_UART_BIT = 8;

  // One PWM config word, seen raw by the bus and split by the channel
  typedef union packed {
    logic [REG_DW-1:0] raw;
    struct packed {
      logic [PWM_CNT_W-1:0] high;
      logic [PWM_CNT_W-1:0] low;
    } fld;
  } pwm_cfg_u;

endpackage

`default_nettype wire
